/* src/rob_size_pkg.sv */
`default_nettype none

package rob_size_pkg;

    // buffer geometry
    localparam int ROB_DEPTH = 16;           // entries in the buffer
    localparam int ROB_IDX_W = 4;            // log2 of depth

    // robid carries one extra wrap bit above the index
    // so a full buffer and an empty one can be told apart
    localparam int ROB_ID_W  = ROB_IDX_W + 1;

    localparam int ENQ_LANES = 2;            // dispatch width

endpackage

`default_nettype wire

/* src/rob_field_pkg.sv */
`default_nettype none

package rob_field_pkg;

    // payload widths held in every entry
    localparam int PC_W   = 32;              // program counter

    // register specifiers
    localparam int LREG_W = 5;               // architectural reg, 32 regs
    localparam int PREG_W = 6;               // physical reg, 64 regs

endpackage

`default_nettype wire

/* src/rob_entry_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rob_entry_if
    import rob_size_pkg::*, rob_field_pkg::*;
();
    // enqueue side, lane 1 lands at wr_idx + 1
    logic                 wr0_en;
    logic                 wr1_en;
    logic [ROB_IDX_W-1:0] wr_idx;
    logic [PC_W-1:0]      pc0,       pc1;
    logic [LREG_W-1:0]    lrd0,      lrd1;
    logic [PREG_W-1:0]    prd0,      prd1;
    logic [PREG_W-1:0]    old_prd0,  old_prd1;
    logic                 need_to_wb0, need_to_wb1;

    // head read port and commit free
    logic [ROB_IDX_W-1:0] head_idx;
    logic                 commit_en;
    logic                 head_valid;
    logic                 head_complete;
    logic [PC_W-1:0]      head_pc;
    logic [LREG_W-1:0]    head_lrd;
    logic [PREG_W-1:0]    head_prd;
    logic [PREG_W-1:0]    head_old_prd;
    logic                 head_need_to_wb;

    // walk read port and rollback kill
    logic [ROB_IDX_W-1:0] walk_idx;
    logic [ROB_DEPTH-1:0] kill_mask;
    logic [LREG_W-1:0]    walk_lrd_rd;
    logic [PREG_W-1:0]    walk_prd_rd;
    logic                 walk_need_rd;
    logic                 walk_complete_rd;

    modport writer (
        output wr0_en, wr1_en, wr_idx, pc0, lrd0, prd0, old_prd0, need_to_wb0,
               pc1, lrd1, prd1, old_prd1, need_to_wb1
    );

    modport retire (
        output head_idx, commit_en,
        input  head_valid, head_complete, head_pc, head_lrd, head_prd,
               head_old_prd, head_need_to_wb
    );

    modport store (
        input  wr0_en, wr1_en, wr_idx, pc0, lrd0, prd0, old_prd0, need_to_wb0,
               pc1, lrd1, prd1, old_prd1, need_to_wb1,
               head_idx, commit_en, walk_idx, kill_mask,
        output head_valid, head_complete, head_pc, head_lrd, head_prd,
               head_old_prd, head_need_to_wb,
               walk_lrd_rd, walk_prd_rd, walk_need_rd, walk_complete_rd
    );

    modport walker (
        output walk_idx, kill_mask,
        input  walk_lrd_rd, walk_prd_rd, walk_need_rd, walk_complete_rd
    );

endinterface

`default_nettype wire

/* src/rob_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_alloc
    import rob_size_pkg::*, rob_field_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset_n,

    input  wire                 instr0_valid,
    input  wire  [PC_W-1:0]     instr0_pc,
    input  wire  [LREG_W-1:0]   instr0_lrd,
    input  wire  [PREG_W-1:0]   instr0_prd,
    input  wire  [PREG_W-1:0]   instr0_old_prd,
    input  wire                 instr0_need_to_wb,

    input  wire                 instr1_valid,
    input  wire  [PC_W-1:0]     instr1_pc,
    input  wire  [LREG_W-1:0]   instr1_lrd,
    input  wire  [PREG_W-1:0]   instr1_prd,
    input  wire  [PREG_W-1:0]   instr1_old_prd,
    input  wire                 instr1_need_to_wb,

    input  wire  [ROB_ID_W-1:0] head_ptr,
    input  wire                 busy,          // rollback or walk in progress
    input  wire                 rollback,
    input  wire  [ROB_ID_W-1:0] restart_ptr,   // flush robid + 1

    output logic [ROB_ID_W-1:0] enq_ptr,
    output logic                can_enq,
    rob_entry_if.writer         wr
);
    logic [ROB_ID_W-1:0] used_cnt;
    logic [ROB_ID_W-1:0] free_cnt;
    logic                lane0_go;
    logic                lane1_go;
    logic [1:0]          enq_num;

    // wrap bit makes the pointer distance exact, 0..16
    assign used_cnt = enq_ptr - head_ptr;
    assign free_cnt = ROB_ID_W'(ROB_DEPTH) - used_cnt;

    // room for a full pair is required even for a single
    assign can_enq = ~busy & (free_cnt >= ROB_ID_W'(ENQ_LANES));

    assign lane0_go = instr0_valid & can_enq;
    assign lane1_go = instr1_valid & lane0_go;   // lane 1 never alone
    assign enq_num  = {1'b0, lane0_go} + {1'b0, lane1_go};

    assign wr.wr0_en      = lane0_go;
    assign wr.wr1_en      = lane1_go;
    assign wr.wr_idx      = enq_ptr[ROB_IDX_W-1:0];

    assign wr.pc0         = instr0_pc;
    assign wr.lrd0        = instr0_lrd;
    assign wr.prd0        = instr0_prd;
    assign wr.old_prd0    = instr0_old_prd;
    assign wr.need_to_wb0 = instr0_need_to_wb;

    assign wr.pc1         = instr1_pc;
    assign wr.lrd1        = instr1_lrd;
    assign wr.prd1        = instr1_prd;
    assign wr.old_prd1    = instr1_old_prd;
    assign wr.need_to_wb1 = instr1_need_to_wb;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else if (rollback) begin
            enq_ptr <= restart_ptr;      // drop everything younger than the flush
        end else begin
            enq_ptr <= enq_ptr + ROB_ID_W'(enq_num);
        end
    end

endmodule

`default_nettype wire

/* src/rob_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array
    import rob_size_pkg::*, rob_field_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset_n,

    input  wire                 int_wb_valid,
    input  wire  [ROB_ID_W-1:0] int_wb_robid,
    input  wire                 mem_wb_valid,
    input  wire  [ROB_ID_W-1:0] mem_wb_robid,

    rob_entry_if.store          ent
);
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] complete_q;

    // payload, written on enqueue only
    logic [PC_W-1:0]      pc_mem      [ROB_DEPTH];
    logic [LREG_W-1:0]    lrd_mem     [ROB_DEPTH];
    logic [PREG_W-1:0]    prd_mem     [ROB_DEPTH];
    logic [PREG_W-1:0]    old_prd_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] need_mem;

    logic [ROB_IDX_W-1:0] wr1_idx;
    logic [ROB_DEPTH-1:0] wr_set;      // entries allocated this cycle
    logic [ROB_DEPTH-1:0] wb_set;      // entries written back this cycle
    logic [ROB_DEPTH-1:0] clr_set;     // committed or killed

    assign wr1_idx = ent.wr_idx + ROB_IDX_W'(1);

    always_comb begin
        wr_set  = '0;
        wb_set  = '0;
        clr_set = ent.kill_mask;
        if (ent.wr0_en) wr_set[ent.wr_idx] = 1'b1;
        if (ent.wr1_en) wr_set[wr1_idx] = 1'b1;
        // both ports may hit in the same cycle
        if (int_wb_valid) wb_set[int_wb_robid[ROB_IDX_W-1:0]] = 1'b1;
        if (mem_wb_valid) wb_set[mem_wb_robid[ROB_IDX_W-1:0]] = 1'b1;
        if (ent.commit_en) clr_set[ent.head_idx] = 1'b1;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q    <= '0;
            complete_q <= '0;
        end else begin
            valid_q    <= (valid_q & ~clr_set) | wr_set;
            // stray writebacks to dead slots are dropped
            complete_q <= (complete_q | (wb_set & valid_q)) & ~wr_set;
        end
    end

    always_ff @(posedge clock) begin
        if (ent.wr0_en) begin
            pc_mem[ent.wr_idx]      <= ent.pc0;
            lrd_mem[ent.wr_idx]     <= ent.lrd0;
            prd_mem[ent.wr_idx]     <= ent.prd0;
            old_prd_mem[ent.wr_idx] <= ent.old_prd0;
            need_mem[ent.wr_idx]    <= ent.need_to_wb0;
        end
        if (ent.wr1_en) begin
            pc_mem[wr1_idx]         <= ent.pc1;
            lrd_mem[wr1_idx]        <= ent.lrd1;
            prd_mem[wr1_idx]        <= ent.prd1;
            old_prd_mem[wr1_idx]    <= ent.old_prd1;
            need_mem[wr1_idx]       <= ent.need_to_wb1;
        end
    end

    // head read port
    assign ent.head_valid      = valid_q[ent.head_idx];
    assign ent.head_complete   = complete_q[ent.head_idx];
    assign ent.head_pc         = pc_mem[ent.head_idx];
    assign ent.head_lrd        = lrd_mem[ent.head_idx];
    assign ent.head_prd        = prd_mem[ent.head_idx];
    assign ent.head_old_prd    = old_prd_mem[ent.head_idx];
    assign ent.head_need_to_wb = need_mem[ent.head_idx];

    // walk read port
    assign ent.walk_lrd_rd      = lrd_mem[ent.walk_idx];
    assign ent.walk_prd_rd      = prd_mem[ent.walk_idx];
    assign ent.walk_need_rd     = need_mem[ent.walk_idx];
    assign ent.walk_complete_rd = complete_q[ent.walk_idx];

endmodule

`default_nettype wire

/* src/rob_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_retire
    import rob_size_pkg::*, rob_field_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset_n,
    input  wire                 busy,

    output logic [ROB_ID_W-1:0] head_ptr,

    output logic                commit_valid,
    output logic [ROB_ID_W-1:0] commit_robid,
    output logic [PC_W-1:0]     commit_pc,
    output logic [LREG_W-1:0]   commit_lrd,
    output logic [PREG_W-1:0]   commit_prd,
    output logic [PREG_W-1:0]   commit_old_prd,
    output logic                commit_need_to_wb,   // arch rat update

    rob_entry_if.retire         rt
);
    // oldest entry leaves once written back, never during recovery
    assign commit_valid = rt.head_valid & rt.head_complete & ~busy;

    assign rt.head_idx  = head_ptr[ROB_IDX_W-1:0];
    assign rt.commit_en = commit_valid;

    assign commit_robid      = head_ptr;
    assign commit_pc         = rt.head_pc;
    assign commit_lrd        = rt.head_lrd;
    assign commit_prd        = rt.head_prd;
    assign commit_old_prd    = rt.head_old_prd;
    assign commit_need_to_wb = rt.head_need_to_wb;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head_ptr <= '0;
        end else if (commit_valid) begin
            head_ptr <= head_ptr + ROB_ID_W'(1);
        end
    end

endmodule

`default_nettype wire

/* src/rob_recovery.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_recovery
    import rob_size_pkg::*, rob_field_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset_n,
    input  wire                 flush_valid,
    input  wire  [ROB_ID_W-1:0] flush_robid,
    input  wire  [ROB_ID_W-1:0] head_ptr,
    input  wire  [ROB_ID_W-1:0] enq_ptr,

    output logic                busy,
    output logic                rollback,
    output logic [ROB_ID_W-1:0] restart_ptr,

    output logic [1:0]          rob_state,
    output logic                walk_valid,
    output logic [LREG_W-1:0]   walk_lrd,
    output logic [PREG_W-1:0]   walk_prd,
    output logic                walk_complete,

    rob_entry_if.walker         wk
);
    localparam logic [1:0] S_IDLE     = 2'b00;
    localparam logic [1:0] S_ROLLBACK = 2'b01;
    localparam logic [1:0] S_WALK     = 2'b10;

    logic [1:0]           state_q, state_d;
    logic [ROB_ID_W-1:0]  flush_q;           // robid of the flushing instr
    logic [ROB_ID_W-1:0]  walk_ptr;
    logic [ROB_IDX_W-1:0] flush_age;         // distance from head
    logic [ROB_ID_W-1:0]  live_cnt;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:     if (flush_valid) state_d = S_ROLLBACK;
            S_ROLLBACK: state_d = S_WALK;
            S_WALK:     if (walk_ptr == flush_q) state_d = S_IDLE;   // last survivor shown
            default:    state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= S_IDLE;
            flush_q  <= '0;
            walk_ptr <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE && flush_valid) flush_q <= flush_robid;
            if (state_q == S_ROLLBACK) begin
                walk_ptr <= head_ptr;            // replay from the oldest
            end else if (state_q == S_WALK) begin
                walk_ptr <= walk_ptr + ROB_ID_W'(1);
            end
        end
    end

    assign flush_age = flush_q[ROB_IDX_W-1:0] - head_ptr[ROB_IDX_W-1:0];
    assign live_cnt  = enq_ptr - head_ptr;

    // kill live entries younger than the flush point
    always_comb begin
        logic [ROB_IDX_W-1:0] entry_age;
        wk.kill_mask = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            entry_age = ROB_IDX_W'(i) - head_ptr[ROB_IDX_W-1:0];
            if (rollback && (entry_age > flush_age) && ({1'b0, entry_age} < live_cnt)) begin
                wk.kill_mask[i] = 1'b1;
            end
        end
    end

    assign wk.walk_idx   = walk_ptr[ROB_IDX_W-1:0];

    assign busy          = (state_q != S_IDLE);
    assign rollback      = (state_q == S_ROLLBACK);
    assign restart_ptr   = flush_q + ROB_ID_W'(1);
    assign rob_state     = state_q;

    assign walk_valid    = (state_q == S_WALK) & wk.walk_need_rd;
    assign walk_lrd      = wk.walk_lrd_rd;
    assign walk_prd      = wk.walk_prd_rd;
    assign walk_complete = wk.walk_complete_rd;

endmodule

`default_nettype wire

/* src/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_top
    import rob_size_pkg::*, rob_field_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset_n,

    input  wire                 instr0_valid,
    input  wire  [PC_W-1:0]     instr0_pc,
    input  wire  [LREG_W-1:0]   instr0_lrd,
    input  wire  [PREG_W-1:0]   instr0_prd,
    input  wire  [PREG_W-1:0]   instr0_old_prd,
    input  wire                 instr0_need_to_wb,
    input  wire                 instr1_valid,
    input  wire  [PC_W-1:0]     instr1_pc,
    input  wire  [LREG_W-1:0]   instr1_lrd,
    input  wire  [PREG_W-1:0]   instr1_prd,
    input  wire  [PREG_W-1:0]   instr1_old_prd,
    input  wire                 instr1_need_to_wb,
    output logic                can_enq,
    output logic [ROB_ID_W-1:0] enq_robid,       // robid of lane 0

    input  wire                 int_wb_valid,
    input  wire  [ROB_ID_W-1:0] int_wb_robid,
    input  wire                 mem_wb_valid,
    input  wire  [ROB_ID_W-1:0] mem_wb_robid,

    output logic                commit_valid,
    output logic [ROB_ID_W-1:0] commit_robid,
    output logic [PC_W-1:0]     commit_pc,
    output logic [LREG_W-1:0]   commit_lrd,
    output logic [PREG_W-1:0]   commit_prd,
    output logic [PREG_W-1:0]   commit_old_prd,
    output logic                commit_need_to_wb,

    input  wire                 flush_valid,
    input  wire  [ROB_ID_W-1:0] flush_robid,
    output logic [1:0]          rob_state,
    output logic                walk_valid,
    output logic [LREG_W-1:0]   walk_lrd,
    output logic [PREG_W-1:0]   walk_prd,
    output logic                walk_complete
);
    logic [ROB_ID_W-1:0] head_ptr;
    logic                busy;
    logic                rollback;
    logic [ROB_ID_W-1:0] restart_ptr;

    rob_entry_if ent_if ();

    rob_alloc u_alloc (
        .clock, .reset_n,
        .instr0_valid, .instr0_pc, .instr0_lrd, .instr0_prd,
        .instr0_old_prd, .instr0_need_to_wb,
        .instr1_valid, .instr1_pc, .instr1_lrd, .instr1_prd,
        .instr1_old_prd, .instr1_need_to_wb,
        .head_ptr, .busy, .rollback, .restart_ptr,
        .enq_ptr (enq_robid),
        .can_enq,
        .wr      (ent_if.writer)
    );

    rob_entry_array u_array (
        .clock, .reset_n,
        .int_wb_valid, .int_wb_robid, .mem_wb_valid, .mem_wb_robid,
        .ent     (ent_if.store)
    );

    rob_retire u_retire (
        .clock, .reset_n, .busy, .head_ptr,
        .commit_valid, .commit_robid, .commit_pc, .commit_lrd,
        .commit_prd, .commit_old_prd, .commit_need_to_wb,
        .rt      (ent_if.retire)
    );

    rob_recovery u_recovery (
        .clock, .reset_n, .flush_valid, .flush_robid, .head_ptr,
        .enq_ptr (enq_robid),
        .busy, .rollback, .restart_ptr,
        .rob_state, .walk_valid, .walk_lrd, .walk_prd, .walk_complete,
        .wk      (ent_if.walker)
    );

endmodule

`default_nettype wire

/* bench/rob_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_chk (
    input wire       clock,
    input wire       reset_n,
    input wire       commit_valid,
    input wire       walk_valid,
    input wire       can_enq,
    input wire [1:0] rob_state
);
    localparam logic [1:0] ST_IDLE   = 2'b00;
    localparam logic [1:0] ST_WALK   = 2'b10;
    localparam logic [1:0] ST_UNUSED = 2'b11;

    // commit is held off for the whole recovery
    commit_walk_excl: assert property (@(posedge clock) disable iff (!reset_n)
        !(commit_valid && walk_valid))
        else $error("commit_valid and walk_valid high in the same cycle");

    state_legal: assert property (@(posedge clock) disable iff (!reset_n)
        rob_state != ST_UNUSED)
        else $error("rob_state took the unused encoding");

    enq_blocked: assert property (@(posedge clock) disable iff (!reset_n)
        (rob_state != ST_IDLE) |-> !can_enq)
        else $error("can_enq high outside the idle state");

    walk_in_walk: assert property (@(posedge clock) disable iff (!reset_n)
        walk_valid |-> (rob_state == ST_WALK))
        else $error("walk_valid high outside the walk state");

endmodule

bind rob_top rob_chk u_chk (
    .clock        (clock),
    .reset_n      (reset_n),
    .commit_valid (commit_valid),
    .walk_valid   (walk_valid),
    .can_enq      (can_enq),
    .rob_state    (rob_state)
);

`default_nettype wire

/* bench/tb_rob.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rob;
    localparam int DEPTH    = 16;
    localparam int LOOP_MAX = 48;           // cycles any wait may take

    localparam logic [2:0] OP_PAIR   = 3'd0;
    localparam logic [2:0] OP_SINGLE = 3'd1;
    localparam logic [2:0] OP_WB     = 3'd2;
    localparam logic [2:0] OP_FLUSH  = 3'd3;
    localparam logic [2:0] OP_IDLE   = 3'd4;
    localparam logic [5:0] NO_ARG    = 6'h3f; // bit 5 set means no strobe

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ROLL = 2'd1;
    localparam logic [1:0] ST_WALK = 2'd2;

    typedef struct packed {
        logic [2:0] op;
        logic [5:0] a;                      // int wb or flush robid
        logic [5:0] b;                      // mem wb robid
        logic       can;                    // can_enq at row start
    } row_t;

    row_t rows [$];

    logic        clock;
    logic        reset_n;
    logic        instr0_valid;
    logic [31:0] instr0_pc;
    logic [4:0]  instr0_lrd;
    logic [5:0]  instr0_prd;
    logic [5:0]  instr0_old_prd;
    logic        instr0_need_to_wb;
    logic        instr1_valid;
    logic [31:0] instr1_pc;
    logic [4:0]  instr1_lrd;
    logic [5:0]  instr1_prd;
    logic [5:0]  instr1_old_prd;
    logic        instr1_need_to_wb;
    wire         can_enq;
    wire  [4:0]  enq_robid;
    logic        int_wb_valid;
    logic [4:0]  int_wb_robid;
    logic        mem_wb_valid;
    logic [4:0]  mem_wb_robid;
    wire         commit_valid;
    wire  [4:0]  commit_robid;
    wire  [31:0] commit_pc;
    wire  [4:0]  commit_lrd;
    wire  [5:0]  commit_prd;
    wire  [5:0]  commit_old_prd;
    wire         commit_need_to_wb;
    logic        flush_valid;
    logic [4:0]  flush_robid;
    wire  [1:0]  rob_state;
    wire         walk_valid;
    wire  [4:0]  walk_lrd;
    wire  [5:0]  walk_prd;
    wire         walk_complete;

    // reference model of the buffer, indexed by robid low bits
    logic [31:0] m_pc   [DEPTH];
    logic [4:0]  m_lrd  [DEPTH];
    logic [5:0]  m_prd  [DEPTH];
    logic [5:0]  m_old  [DEPTH];
    logic        m_need [DEPTH];
    logic        m_cmp  [DEPTH];
    logic        m_live [DEPTH];
    logic [4:0]  m_head;
    logic [4:0]  m_enq;
    logic [4:0]  m_flush;
    logic [4:0]  m_walk;
    logic [1:0]  m_state;
    logic [31:0] seed;

    rob_top u_dut (.*);

    always #2 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // two free slots needed, even for a single
    function automatic logic expect_can();
        logic [4:0] used;
        used = m_enq - m_head;
        return (m_state == ST_IDLE) && (used <= 5'd14);
    endfunction

    function automatic logic commit_due();
        return (m_state == ST_IDLE) && m_live[m_head[3:0]] && m_cmp[m_head[3:0]];
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            stop_run($sformatf("** Error at %0d ns: %s expected %0h, got %0h",
                               $time, name, exp, act));
        end
    endtask

    task automatic random_fields(output logic [31:0] pc, output logic [4:0] lrd,
                                 output logic [5:0] prd, output logic [5:0] old_prd,
                                 output logic need);
        logic [31:0] r;
        r       = lcg_next();
        pc      = {r[31:2], 2'b00};
        r       = lcg_next();
        lrd     = r[20:16];
        prd     = r[13:8];
        old_prd = r[29:24];
        need    = r[30];
    endtask

    task automatic clear_inputs();
        instr0_valid = 1'b0;
        instr1_valid = 1'b0;
        int_wb_valid = 1'b0;
        mem_wb_valid = 1'b0;
        flush_valid  = 1'b0;
    endtask

    task automatic store_entry(input logic [3:0] idx, input logic [31:0] pc,
                               input logic [4:0] lrd, input logic [5:0] prd,
                               input logic [5:0] old_prd, input logic need);
        m_pc[idx]   = pc;
        m_lrd[idx]  = lrd;
        m_prd[idx]  = prd;
        m_old[idx]  = old_prd;
        m_need[idx] = need;
        m_cmp[idx]  = 1'b0;
        m_live[idx] = 1'b1;
    endtask

    task automatic verify_outputs();
        logic [3:0] hi;
        logic [3:0] wi;
        logic       exp_commit;
        hi         = m_head[3:0];
        wi         = m_walk[3:0];
        exp_commit = commit_due();
        compare("can_enq", 32'(expect_can()), 32'(can_enq));
        compare("enq_robid", 32'(m_enq), 32'(enq_robid));
        compare("rob_state", 32'(m_state), 32'(rob_state));
        compare("commit_valid", 32'(exp_commit), 32'(commit_valid));
        if (exp_commit) begin
            compare("commit_robid", 32'(m_head), 32'(commit_robid));
            compare("commit_pc", m_pc[hi], commit_pc);
            compare("commit_lrd", 32'(m_lrd[hi]), 32'(commit_lrd));
            compare("commit_prd", 32'(m_prd[hi]), 32'(commit_prd));
            compare("commit_old_prd", 32'(m_old[hi]), 32'(commit_old_prd));
            compare("commit_need_to_wb", 32'(m_need[hi]), 32'(commit_need_to_wb));
        end
        compare("walk_valid", 32'((m_state == ST_WALK) && m_need[wi]), 32'(walk_valid));
        if (m_state == ST_WALK) begin
            compare("walk_lrd", 32'(m_lrd[wi]), 32'(walk_lrd));
            compare("walk_prd", 32'(m_prd[wi]), 32'(walk_prd));
            compare("walk_complete", 32'(m_cmp[wi]), 32'(walk_complete));
        end
    endtask

    // model effect of the coming clock edge
    task automatic update_model();
        logic       go;
        logic       retire;
        logic [4:0] r;
        go     = expect_can() && instr0_valid;
        retire = commit_due();
        if (int_wb_valid && m_live[int_wb_robid[3:0]])
            m_cmp[int_wb_robid[3:0]] = 1'b1;
        if (mem_wb_valid && m_live[mem_wb_robid[3:0]])
            m_cmp[mem_wb_robid[3:0]] = 1'b1;
        if (go) begin
            store_entry(m_enq[3:0], instr0_pc, instr0_lrd, instr0_prd, instr0_old_prd,
                        instr0_need_to_wb);
            if (instr1_valid)
                store_entry(m_enq[3:0] + 4'd1, instr1_pc, instr1_lrd, instr1_prd,
                            instr1_old_prd, instr1_need_to_wb);
            m_enq = m_enq + (instr1_valid ? 5'd2 : 5'd1);
        end
        if (retire) begin
            m_live[m_head[3:0]] = 1'b0;
            m_head = m_head + 5'd1;
        end
        case (m_state)
            ST_IDLE: begin
                if (flush_valid) begin
                    m_flush = flush_robid;
                    m_state = ST_ROLL;
                end
            end
            ST_ROLL: begin
                // everything younger than the flush point dies
                for (r = m_flush + 5'd1; r != m_enq; r = r + 5'd1)
                    m_live[r[3:0]] = 1'b0;
                m_enq   = m_flush + 5'd1;
                m_walk  = m_head;
                m_state = ST_WALK;
            end
            default: begin
                if (m_walk == m_flush)
                    m_state = ST_IDLE;
                m_walk = m_walk + 5'd1;
            end
        endcase
    endtask

    task automatic run_cycle(input logic use_row, input logic row_can);
        #2;
        if (use_row)
            compare("can_enq (table)", 32'(row_can), 32'(can_enq));
        verify_outputs();
        update_model();
        @(posedge clock);
        #1;
        clear_inputs();
    endtask

    task automatic drive_enqueue(input logic both);
        instr0_valid = 1'b1;
        random_fields(instr0_pc, instr0_lrd, instr0_prd, instr0_old_prd, instr0_need_to_wb);
        instr1_valid = both;
        random_fields(instr1_pc, instr1_lrd, instr1_prd, instr1_old_prd, instr1_need_to_wb);
    endtask

    task automatic finish_recovery();
        int n;
        n = 0;
        while (rob_state != ST_IDLE) begin
            run_cycle(1'b0, 1'b0);
            n++;
            if (n > LOOP_MAX)
                stop_run("timeout: rob_state did not return to idle after a flush");
        end
    endtask

    task automatic drain_commits();
        int n;
        n = 0;
        while (commit_valid) begin
            run_cycle(1'b0, 1'b0);
            n++;
            if (n > LOOP_MAX)
                stop_run("timeout: commit_valid stayed high while draining");
        end
    endtask

    task automatic apply_row(input row_t row);
        case (row.op)
            OP_PAIR:   drive_enqueue(1'b1);
            OP_SINGLE: drive_enqueue(1'b0);
            OP_WB: begin
                int_wb_valid = ~row.a[5];
                int_wb_robid = row.a[4:0];
                mem_wb_valid = ~row.b[5];
                mem_wb_robid = row.b[4:0];
            end
            OP_FLUSH: begin
                flush_valid = 1'b1;
                flush_robid = row.a[4:0];
            end
            default: ;
        endcase
        run_cycle(1'b1, row.can);
        if (row.op == OP_FLUSH)
            finish_recovery();
        if (row.op == OP_IDLE)
            drain_commits();
    endtask

    task automatic add_row(input logic [2:0] op, input logic [5:0] a, input logic [5:0] b,
                           input logic can);
        row_t row;
        row.op  = op;
        row.a   = a;
        row.b   = b;
        row.can = can;
        rows.push_back(row);
    endtask

    task automatic build_table();
        // enqueue, out of order writeback on both ports
        add_row(OP_PAIR, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_SINGLE, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_PAIR, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_WB, 6'd2, 6'd4, 1'b1);
        add_row(OP_WB, 6'd0, NO_ARG, 1'b1);
        add_row(OP_WB, 6'd3, 6'd1, 1'b1);
        add_row(OP_IDLE, NO_ARG, NO_ARG, 1'b1);
        // fill all 16 slots, robids 5..20 wrap the index
        repeat (8) add_row(OP_PAIR, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_PAIR, NO_ARG, NO_ARG, 1'b0);
        add_row(OP_SINGLE, NO_ARG, NO_ARG, 1'b0);
        add_row(OP_WB, 6'd6, 6'd5, 1'b0);
        add_row(OP_WB, 6'd8, 6'd7, 1'b0);
        add_row(OP_WB, 6'd10, 6'd9, 1'b0);
        add_row(OP_WB, 6'd12, 6'd11, 1'b1);
        add_row(OP_WB, 6'd13, 6'd14, 1'b1);
        add_row(OP_WB, 6'd15, 6'd16, 1'b1);
        add_row(OP_WB, 6'd17, 6'd18, 1'b1);
        add_row(OP_WB, 6'd19, 6'd20, 1'b1);
        add_row(OP_IDLE, NO_ARG, NO_ARG, 1'b1);
        // flush at 23, 21..23 survive
        repeat (3) add_row(OP_PAIR, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_WB, 6'd22, NO_ARG, 1'b1);
        add_row(OP_FLUSH, 6'd23, NO_ARG, 1'b1);
        // survivors retire, killed robids get reused
        add_row(OP_WB, 6'd21, 6'd23, 1'b1);
        add_row(OP_PAIR, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_IDLE, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_WB, 6'd25, 6'd24, 1'b1);
        add_row(OP_IDLE, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_PAIR, NO_ARG, NO_ARG, 1'b1);
        add_row(OP_FLUSH, 6'd26, NO_ARG, 1'b1);   // only the head survives
        add_row(OP_WB, 6'd26, NO_ARG, 1'b1);
        add_row(OP_IDLE, NO_ARG, NO_ARG, 1'b1);
    endtask

    initial begin
        seed    = 32'h78b1c2a3;
        clock   = 1'b0;
        reset_n = 1'b0;
        clear_inputs();
        instr0_pc = '0;
        instr0_lrd = '0;
        instr0_prd = '0;
        instr0_old_prd = '0;
        instr0_need_to_wb = 1'b0;
        instr1_pc = '0;
        instr1_lrd = '0;
        instr1_prd = '0;
        instr1_old_prd = '0;
        instr1_need_to_wb = 1'b0;
        int_wb_robid = '0;
        mem_wb_robid = '0;
        flush_robid  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            store_entry(4'(i), '0, '0, '0, '0, 1'b0);
            m_live[i] = 1'b0;
        end
        m_head  = '0;
        m_enq   = '0;
        m_flush = '0;
        m_walk  = '0;
        m_state = ST_IDLE;
        build_table();

        repeat (2) @(posedge clock);
        #1;
        reset_n = 1'b1;
        compare("commit_valid", 32'd0, 32'(commit_valid));
        compare("walk_valid", 32'd0, 32'(walk_valid));
        compare("rob_state", 32'(ST_IDLE), 32'(rob_state));
        compare("can_enq", 32'd1, 32'(can_enq));
        compare("enq_robid", 32'd0, 32'(enq_robid));

        foreach (rows[i])
            apply_row(rows[i]);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
src/rob_size_pkg.sv
src/rob_field_pkg.sv
src/rob_entry_if.sv
src/rob_alloc.sv
src/rob_entry_array.sv
src/rob_retire.sv
src/rob_recovery.sv
src/rob_top.sv
bench/rob_chk.sv
bench/tb_rob.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_rob
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only
PASS_MSG   ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
